/* sim.f */
common/lane_pkg.sv
src/frame_buffer.sv
overlay/line_drawer.sv
overlay/pixel_composer.sv
uart/uart_tx.sv
src/frame_sequencer.sv
src/lane_overlay_top.sv
verification/tb_lane_overlay.sv

/* Bender.yml */
package:
  name: lane_overlay

sources:
  - common/lane_pkg.sv
  - src/frame_buffer.sv
  - overlay/line_drawer.sv
  - overlay/pixel_composer.sv
  - uart/uart_tx.sv
  - src/frame_sequencer.sv
  - src/lane_overlay_top.sv
  - target: simulation
    files:
      - verification/tb_lane_overlay.sv

/* verification/tb_lane_overlay.sv */
`timescale 1ns/1ps

module tb_lane_overlay;
    import lane_pkg::*;

    localparam int     n_bytes     = total_px * 3;                 // bytes in one frame
    localparam longint watchdog_ns = longint'(n_bytes) * 10 * (clks_per_bit + 8) * 4 * 10;

    logic       CLK100MHZ = 1'b0;
    logic       HT_reset_complete;
    logic       start;
    logic       load_en;
    px_addr_t   load_addr;
    pixel_t     load_data;
    slope_t     left_m;
    intercept_t left_b;
    slope_t     right_m;
    intercept_t right_b;
    logic       uart_txd;
    logic       frame_active;

    int     seed = 72455;                                          // fixed stimulus seed
    pixel_t gray_ref [0:total_px-1];                               // copy of the loaded frame

    lane_overlay_top u_lane_overlay_top (.*);

    always #5 CLK100MHZ = ~CLK100MHZ;                              // 100 MHz

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    ///////////////////////////////
    // reference model
    function automatic bit on_line(input int m, input int b, input int x, input int y);
        longint prod;
        prod = longint'(m) * x;                                    // Q8.8 times integer
        return ((prod >>> 8) + b) == y;
    endfunction

    function automatic int expected_byte(input int px, input int ch);
        int x;
        int y;
        x = px % img_width;
        y = px / img_width;
        if (y < border_rows || x < border_cols) return 0;          // black edge
        if (on_line(left_m, left_b, x, y)) return (ch == chan_blue) ? 255 : 0;
        if (on_line(right_m, right_b, x, y)) return (ch == chan_red) ? 255 : 0;
        return gray_ref[px];                                       // gray on every channel
    endfunction

    ///////////////////////////////
    // stimulus and uart receiver
    task automatic pulse_start();
        @(posedge CLK100MHZ) start <= 1'b1;
        @(posedge CLK100MHZ) start <= 1'b0;                        // one cycle strobe
    endtask

    task automatic load_frame();
        for (int i = 0; i < total_px; i++) begin
            @(posedge CLK100MHZ);
            gray_ref[i] = pixel_t'($random(seed));
            load_en   <= 1'b1;
            load_addr <= px_addr_t'(i);
            load_data <= gray_ref[i];
        end
        @(posedge CLK100MHZ) load_en <= 1'b0;
    endtask

    task automatic set_lines(input int lm, input int lb, input int rm, input int rb);
        @(posedge CLK100MHZ);
        left_m  <= slope_t'(lm);
        left_b  <= intercept_t'(lb);
        right_m <= slope_t'(rm);
        right_b <= intercept_t'(rb);
    endtask

    task automatic receive_byte(input string name, output int value);
        pixel_t data;
        @(negedge CLK100MHZ);
        while (uart_txd !== 1'b0) @(negedge CLK100MHZ);           // hunt for start bit
        repeat (clks_per_bit / 2) @(negedge CLK100MHZ);            // move to bit centre
        assert (uart_txd === 1'b0) else report_failure({name, ": start bit did not hold low"});
        for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(negedge CLK100MHZ);
            data[i] = uart_txd;                                    // lsb first
        end
        repeat (clks_per_bit) @(negedge CLK100MHZ);
        assert (uart_txd === 1'b1) else report_failure({name, ": stop bit was low"});
        value = data;
    endtask

    // line must stay idle, so the frame held no extra byte
    task automatic check_quiet(input string name);
        repeat (20 * clks_per_bit) begin
            @(negedge CLK100MHZ);
            assert (uart_txd === 1'b1 && frame_active === 1'b0)
                else report_failure({name, ": activity after the frame had ended"});
        end
    endtask

    task automatic run_frame(input string name, input int restart_at);
        int got;
        int exp;
        pulse_start();
        for (int n = 0; n < n_bytes; n++) begin
            receive_byte(name, got);
            exp = expected_byte(n / 3, n % 3);
            assert (got == exp) else report_failure($sformatf(
                "error: %s byte %0d expected %0d actual %0d", name, n, exp, got));
            if (n == restart_at) pulse_start();                    // busy, must be ignored
        end
        assert (frame_active === 1'b0) else report_failure($sformatf(
            "error: %s frame_active expected 0 actual %b", name, frame_active));
        check_quiet(name);
    endtask

    ///////////////////////////////
    // directed tests
    task automatic test_idle_after_reset();
        repeat (50) begin
            @(negedge CLK100MHZ);
            assert (uart_txd === 1'b1 && frame_active === 1'b0) else report_failure($sformatf(
                "error: idle_after_reset expected txd 1 active 0 actual txd %b active %b",
                uart_txd, frame_active));
        end
    endtask

    task automatic test_plain_frame();
        set_lines(0, 1000, 0, -1000);                              // both lines off screen
        run_frame("plain_frame", -1);
    endtask

    task automatic test_left_line();
        set_lines(0, 5, 0, -1000);                                 // row 5 turns blue
        run_frame("left_line", -1);
    endtask

    task automatic test_right_line_priority();
        set_lines(-256, 20, 256, 0);                               // cross at 10,10
        run_frame("right_line_priority", -1);
    endtask

    task automatic test_start_while_busy();
        set_lines(128, 3, 256, 0);
        run_frame("start_while_busy", 100);                        // restart mid frame
        run_frame("start_after_done", -1);
    endtask

    initial begin
        HT_reset_complete <= 1'b1;
        start     <= 1'b0;
        load_en   <= 1'b0;
        load_addr <= '0;
        load_data <= '0;
        left_m    <= '0;
        left_b    <= '0;
        right_m   <= '0;
        right_b   <= '0;
        repeat (3) @(posedge CLK100MHZ);
        HT_reset_complete <= 1'b0;
        test_idle_after_reset();
        load_frame();
        test_plain_frame();
        test_left_line();
        test_right_line_priority();
        test_start_while_busy();
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        report_failure("watchdog expired before the tests completed");
    end

endmodule

/* src/lane_overlay_top.sv */
`timescale 1ns/1ps

module lane_overlay_top (
    input  logic                   CLK100MHZ,
    input  logic                   HT_reset_complete,
    input  logic                   start,
    input  logic                   load_en,
    input  lane_pkg::px_addr_t     load_addr,
    input  lane_pkg::pixel_t       load_data,
    input  lane_pkg::slope_t       left_m,
    input  lane_pkg::intercept_t   left_b,
    input  lane_pkg::slope_t       right_m,
    input  lane_pkg::intercept_t   right_b,
    output logic                   uart_txd,
    output logic                   frame_active
);
    import lane_pkg::*;

    px_addr_t rd_addr;                                  // sequencer read address
    pixel_t   rd_data;                                  // buffer read data
    pixel_t   gray;                                     // current gray value
    coord_t   x;
    coord_t   y;
    chan_t    chan;                                     // current colour channel
    logic     on_left;
    logic     on_right;
    pixel_t   out_byte;                                 // byte for the uart
    logic     send;
    logic     ready;

    frame_buffer u_frame_buffer (
        .CLK100MHZ (CLK100MHZ),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    frame_sequencer u_frame_sequencer (
        .CLK100MHZ         (CLK100MHZ),
        .HT_reset_complete (HT_reset_complete),
        .start             (start),
        .ready             (ready),
        .rd_data           (rd_data),
        .rd_addr           (rd_addr),
        .gray              (gray),
        .x                 (x),
        .y                 (y),
        .chan              (chan),
        .send              (send),
        .frame_active      (frame_active)
    );

    //////////////////////////////
    // overlay path
    line_drawer u_left_line (
        .CLK100MHZ (CLK100MHZ),
        .m         (left_m),
        .b         (left_b),
        .x         (x),
        .y         (y),
        .on_line   (on_left)
    );

    line_drawer u_right_line (
        .CLK100MHZ (CLK100MHZ),
        .m         (right_m),
        .b         (right_b),
        .x         (x),
        .y         (y),
        .on_line   (on_right)
    );

    pixel_composer u_pixel_composer (
        .CLK100MHZ (CLK100MHZ),
        .gray      (gray),
        .x         (x),
        .y         (y),
        .chan      (chan),
        .on_left   (on_left),
        .on_right  (on_right),
        .out_byte  (out_byte)
    );

    uart_tx u_uart_tx (
        .CLK100MHZ         (CLK100MHZ),
        .HT_reset_complete (HT_reset_complete),
        .send              (send),
        .data              (out_byte),
        .ready             (ready),
        .txd               (uart_txd)
    );

endmodule

/* src/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer (
    input  logic               CLK100MHZ,
    input  logic               HT_reset_complete,
    input  logic               start,
    input  logic               ready,
    input  lane_pkg::pixel_t   rd_data,
    output lane_pkg::px_addr_t rd_addr,
    output lane_pkg::pixel_t   gray,
    output lane_pkg::coord_t   x,
    output lane_pkg::coord_t   y,
    output lane_pkg::chan_t    chan,
    output logic               send,
    output logic               frame_active
);
    import lane_pkg::*;

    seq_state_t state;                                  // output fsm
    logic [1:0] wait_cnt;                               // buffer priming counter
    logic       last_chan;                              // third byte of a pixel
    logic       last_px;                                // bottom right pixel

    assign last_chan    = (chan == chan_t'(2));
    assign last_px      = (x == coord_t'(img_width - 1)) && (y == coord_t'(img_height - 1));
    assign frame_active = (state != st_idle);           // busy for the whole frame

    //////////////////////////////
    // control fsm
    //////////////////////////////
    always_ff @(posedge CLK100MHZ) begin
        if (HT_reset_complete) begin
            state    <= st_idle;
            send     <= 1'b0;
            wait_cnt <= '0;
            chan     <= '0;
            rd_addr  <= '0;
            x        <= '0;
            y        <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin                    // start only seen while idle
                        state    <= st_mem_wait;
                        wait_cnt <= '0;
                        rd_addr  <= '0;                 // first pixel read goes out now
                    end
                end

                st_mem_wait: begin
                    wait_cnt <= wait_cnt + 2'd1;
                    if (wait_cnt == 2'(2 * mem_latency - 1)) begin
                        state <= st_access;
                        chan  <= chan_t'(2);            // forces a pixel fetch on first access
                        x     <= coord_t'(img_width - 1); // wraps to 0,0 on first fetch
                        y     <= '1;
                    end
                end

                st_access: begin
                    if (last_chan) begin                // channel wrap, move to next pixel
                        chan    <= '0;
                        rd_addr <= (rd_addr == px_addr_t'(total_px - 1)) ?
                                   '0 : rd_addr + 1'b1; // prefetch the one after
                        if (x == coord_t'(img_width - 1)) begin
                            x <= '0;
                            y <= y + 1'b1;              // next row
                        end else begin
                            x <= x + 1'b1;
                        end
                    end else begin
                        chan <= chan + 1'b1;            // next colour of same pixel
                    end
                    state <= st_draw;
                end

                st_draw: begin
                    state <= st_send;                   // line drawers register here
                end

                st_send: begin
                    if (!send) begin
                        if (ready) begin
                            send <= 1'b1;               // composer byte valid by now
                        end
                    end else begin
                        send <= 1'b0;                   // single cycle strobe
                        if (last_chan && last_px) begin
                            state <= st_idle;           // frame done
                        end else begin
                            state <= st_access;
                        end
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // gray value of the current pixel, taken at the channel wrap
    always_ff @(posedge CLK100MHZ) begin
        if (state == st_access && last_chan) begin
            gray <= rd_data;                            // buffer output settled long ago
        end
    end

endmodule

/* uart/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic             CLK100MHZ,
    input  logic             HT_reset_complete,
    input  logic             send,
    input  lane_pkg::pixel_t data,
    output logic             ready,
    output logic             txd
);
    import lane_pkg::*;

    logic [9:0]        frame_sr;                        // stop, data, start; lsb goes out
    logic [baud_w-1:0] baud_cnt;                        // clocks within a bit
    logic [3:0]        bit_cnt;                         // bit position 0..9
    logic              busy;                            // frame in flight

    assign ready = ~busy;
    assign txd   = frame_sr[0];                         // idles high, shifted in ones

    //////////////////////////////
    // 8N1 shifter
    //////////////////////////////
    always_ff @(posedge CLK100MHZ) begin
        if (HT_reset_complete) begin
            busy     <= 1'b0;
            frame_sr <= '1;                             // line idle
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (send) begin
                frame_sr <= {1'b1, data, 1'b0};         // start bit on the next edge
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (baud_cnt == baud_w'(clks_per_bit - 1)) begin
            baud_cnt <= '0;
            frame_sr <= {1'b1, frame_sr[9:1]};          // next bit, lsb first
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;                           // stop bit done
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

/* overlay/pixel_composer.sv */
`timescale 1ns/1ps

module pixel_composer (
    input  logic             CLK100MHZ,
    input  lane_pkg::pixel_t gray,
    input  lane_pkg::coord_t x,
    input  lane_pkg::coord_t y,
    input  lane_pkg::chan_t  chan,
    input  logic             on_left,
    input  logic             on_right,
    output lane_pkg::pixel_t out_byte
);
    import lane_pkg::*;

    logic border;                                       // pixel in the black frame edge
    logic is_blue;                                      // current byte is the blue channel
    logic is_red;                                       // current byte is the red channel

    assign border  = (y < coord_t'(border_rows)) || (x < coord_t'(border_cols));
    assign is_blue = (chan == chan_t'(chan_blue));
    assign is_red  = (chan == chan_t'(chan_red));

    //////////////////////////////
    // priority: border, left, right, gray
    always_ff @(posedge CLK100MHZ) begin
        if (border) begin
            out_byte <= '0;                             // black edge
        end else if (on_left) begin
            out_byte <= is_blue ? '1 : '0;              // blue, wins over right
        end else if (on_right) begin
            out_byte <= is_red ? '1 : '0;               // red
        end else begin
            out_byte <= gray;                           // same gray on all channels
        end
    end

endmodule

/* overlay/line_drawer.sv */
`timescale 1ns/1ps

module line_drawer (
    input  logic                 CLK100MHZ,
    input  lane_pkg::slope_t     m,
    input  lane_pkg::intercept_t b,
    input  lane_pkg::coord_t     x,
    input  lane_pkg::coord_t     y,
    output logic                 on_line
);
    import lane_pkg::*;

    // full width keeps the product and the sum exact
    logic signed [$bits(slope_t)+coord_w:0] x_s;       // x, zero extended signed
    logic signed [$bits(slope_t)+coord_w:0] y_s;       // y, zero extended signed
    logic signed [$bits(slope_t)+coord_w:0] product;   // m * x, still Q.8
    logic signed [$bits(slope_t)+coord_w:0] line_y;    // y of the line at this x

    assign x_s     = $signed({{($bits(slope_t)+1){1'b0}}, x});
    assign y_s     = $signed({{($bits(slope_t)+1){1'b0}}, y});
    assign product = m * x_s;                           // signed multiply
    assign line_y  = (product >>> 8) + b;               // drop the 8 fraction bits

    //////////////////////////////
    // one cycle compare
    always_ff @(posedge CLK100MHZ) begin
        on_line <= (line_y == y_s);                     // pixel sits on the line
    end

endmodule

/* src/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer (
    input  logic               CLK100MHZ,
    input  logic               load_en,
    input  lane_pkg::px_addr_t load_addr,
    input  lane_pkg::pixel_t   load_data,
    input  lane_pkg::px_addr_t rd_addr,
    output lane_pkg::pixel_t   rd_data
);
    import lane_pkg::*;

    pixel_t   mem [0:total_px-1];                       // grayscale frame
    px_addr_t addr_q;                                   // registered read address

    // write side, loaded by the testbench
    always_ff @(posedge CLK100MHZ) begin
        if (load_en) begin
            mem[load_addr] <= load_data;                // store on the load edge
        end
    end

    //////////////////////////////
    // read side, two register stages like a block ram with output reg
    always_ff @(posedge CLK100MHZ) begin
        addr_q  <= rd_addr;                             // stage 1 address
        rd_data <= mem[addr_q];                         // stage 2 data out
    end

endmodule

/* common/lane_pkg.sv */
package lane_pkg;

    //////////////////////////////
    // frame geometry
    //////////////////////////////
    localparam int img_width   = 32;                    // pixels per row, shrunk for sim
    localparam int img_height  = 24;                    // rows per frame
    localparam int total_px    = img_width * img_height; // 768 pixels
    localparam int addr_w      = 10;                    // enough for total_px
    localparam int coord_w     = 12;                    // x / y coordinate width

    //////////////////////////////
    // uart timing
    //////////////////////////////
    localparam int clks_per_bit = 16;                   // 868 gives 115200 baud at 100 MHz
    localparam int baud_w       = $clog2(clks_per_bit); // baud counter width

    //////////////////////////////
    // overlay constants
    //////////////////////////////
    localparam int mem_latency = 2;                     // frame buffer read latency
    localparam int border_cols = 2;                     // left columns sent black
    localparam int border_rows = 1;                     // top rows sent black
    localparam int chan_red    = 0;                     // first byte of a pixel
    localparam int chan_blue   = 2;                     // last byte of a pixel

    typedef logic [7:0]            pixel_t;             // gray value or output byte
    typedef logic [addr_w-1:0]     px_addr_t;           // frame buffer address
    typedef logic [coord_w-1:0]    coord_t;             // unsigned x or y
    typedef logic signed [15:0]    slope_t;             // gradient, Q8.8
    typedef logic signed [15:0]    intercept_t;         // y-intercept, integer
    typedef logic [1:0]            chan_t;              // colour channel 0..2

    // output sequencer states
    typedef enum logic [2:0] {
        st_idle,                                        // waiting for start
        st_mem_wait,                                    // priming the buffer read
        st_access,                                      // step channel, fetch next pixel
        st_draw,                                        // line test settles
        st_send                                         // hand byte to uart
    } seq_state_t;

endpackage
